// ==== Makefile ====
# Verilator build and run of the I/O predication testbench
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP ?= ioPredicationTb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
FAIL_MESSAGE ?= Test failed

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := src/ioPredication_settings.svh
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# A non-zero exit status or the fail message in the log fails the run
run: compile
	@./$(BINARY) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MESSAGE)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== src/ioPortCheck.sv ====
// ---------------------------------------
// I/O port check
// Two-stage decode of one address against a port window, then selection of the
// addressed port's EmptyFull flag one cycle later
// ---------------------------------------

`include "ioPredication_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module ioPortCheck #(
    // First address of the port window, a multiple of the port count
    parameter ioPredicationPkg::ioAddr baseAddr = `IO_ADDR_WIDTH'(`IO_READ_BASE),
    // Flag value that blocks the access: 0 (empty) for reads, 1 (full) for writes
    parameter logic blockingState = 1'b0
) (
    input  logic clock,
    input  logic rst,
    input  logic enable,
    input  ioPredicationPkg::ioAddr addr,
    input  ioPredicationPkg::portMask emptyFull,
    output ioPredicationPkg::portCheck check
);

    // The window is aligned to the port count, so an address is inside it
    // exactly when its upper bits match the upper bits of the base
    localparam int tagWidth = `IO_ADDR_WIDTH - `IO_PORT_INDEX_WIDTH;
    localparam logic [tagWidth-1:0] windowTag =
        baseAddr[`IO_ADDR_WIDTH-1:`IO_PORT_INDEX_WIDTH];

    // Stage 1 registers
    logic stage1IsIo;
    ioPredicationPkg::portIndex stage1Index;

    // Stage 1 decode, combinational
    logic inWindow;
    ioPredicationPkg::portIndex addrIndex;

    // Stage 2 flag selection, combinational
    logic selectedFlag;
    logic blocked;

    // ---------------------------------------
    // Stage 1: address decode
    // ---------------------------------------

    // Compare the tag bits against the window and split off the port number
    always_comb begin
        inWindow = (addr[`IO_ADDR_WIDTH-1:`IO_PORT_INDEX_WIDTH] == windowTag);
        addrIndex = addr[`IO_PORT_INDEX_WIDTH-1:0];
    end

    // An instruction that is not enabled never counts as an I/O access,
    // so it can neither block nor raise an enable downstream
    always_ff @(posedge clock) begin
        if (rst) begin
            stage1IsIo <= 1'b0;
            stage1Index <= '0;
        end else begin
            stage1IsIo <= inWindow & enable;
            stage1Index <= addrIndex;
        end
    end

    // ---------------------------------------
    // Stage 2: flag selection
    // ---------------------------------------

    // The flags are sampled one cycle after the address, which is when the
    // port FIFOs present the state that this instruction will meet
    always_comb begin
        selectedFlag = emptyFull[stage1Index];
        blocked = stage1IsIo & (selectedFlag == blockingState);
    end

    // The index and isIo travel with notReady so that the parent sees all
    // three fields for the same instruction in the same cycle
    always_ff @(posedge clock) begin
        if (rst) begin
            check <= '0;
        end else begin
            check.isIo <= stage1IsIo;
            check.index <= stage1Index;
            check.notReady <= blocked;
        end
    end

endmodule

`default_nettype wire

// ==== src/ioPredication.sv ====
// ---------------------------------------
// I/O predication top level
// Joins the read and write predication sides and forms the ioReady level
// that gates every port enable of the instruction
// ---------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ioPredication (
    input  logic clock,
    input  logic rst,
    input  logic enable,
    // Read operands and destination of the instruction entering this cycle
    input  ioPredicationPkg::ioAddr addrA,
    input  ioPredicationPkg::ioAddr addrB,
    input  ioPredicationPkg::ioAddr addrD,
    // EmptyFull flags of the read and write ports, sampled every cycle
    input  ioPredicationPkg::portMask readEmptyFull,
    input  ioPredicationPkg::portMask writeEmptyFull,
    // High when every port the instruction in stage 2 touches can proceed
    output logic ioReady,
    // One-hot port enables, zero when the instruction is annulled
    output ioPredicationPkg::portMask readPortEnableA,
    output ioPredicationPkg::portMask readPortEnableB,
    output ioPredicationPkg::portMask writePortEnable
);

    logic notReadyA;
    logic notReadyB;
    logic notReadyD;

    // ---------------------------------------
    // Read side
    // ---------------------------------------

    ioReadPredication readPred (
        .clock       (clock),
        .rst         (rst),
        .enable      (enable),
        .addrA       (addrA),
        .addrB       (addrB),
        .emptyFull   (readEmptyFull),
        .ioReady     (ioReady),
        .notReadyA   (notReadyA),
        .notReadyB   (notReadyB),
        .portEnableA (readPortEnableA),
        .portEnableB (readPortEnableB)
    );

    // ---------------------------------------
    // Write side
    // ---------------------------------------

    ioWritePredication writePred (
        .clock      (clock),
        .rst        (rst),
        .enable     (enable),
        .addrD      (addrD),
        .emptyFull  (writeEmptyFull),
        .ioReady    (ioReady),
        .notReadyD  (notReadyD),
        .portEnable (writePortEnable)
    );

    // ---------------------------------------
    // Readiness
    // ---------------------------------------

    // The three notReady bits belong to the same instruction, since all
    // checks share the same two-stage latency.
    // Any single blocked port annuls the whole instruction, and with all
    // pipeline registers cleared by reset this level starts out high
    assign ioReady = ~(notReadyA | notReadyB | notReadyD);

endmodule

`default_nettype wire

// ==== src/ioPredicationPkg.sv ====
// ---------------------------------------
// I/O predication types
// Address, port index and port mask vectors, the per-operand check result,
// and the one-hot port decode that both predication sides use
// ---------------------------------------

`include "ioPredication_settings.svh"
`default_nettype none

package ioPredicationPkg;

    typedef logic [`IO_ADDR_WIDTH-1:0] ioAddr;
    typedef logic [`IO_PORT_INDEX_WIDTH-1:0] portIndex;

    // One bit per port, used for EmptyFull flag vectors and for one-hot enables
    typedef logic [`IO_PORT_COUNT-1:0] portMask;

    // Result of checking one address against one port window
    typedef struct packed {
        logic isIo;
        portIndex index;
        logic notReady;
    } portCheck;

    // Turns a port number into its one-hot enable
    function automatic portMask oneHot(input portIndex index);
        return portMask'(1) << index;
    endfunction

endpackage

`default_nettype wire

// ==== src/ioPredication_settings.svh ====
// ---------------------------------------
// I/O predication settings
// Address width, port count and the base addresses of the read and write port windows
// ---------------------------------------

`default_nettype none

`ifndef IO_PREDICATION_SETTINGS_SVH
`define IO_PREDICATION_SETTINGS_SVH

// Width of an operand or destination address
`define IO_ADDR_WIDTH 10

// Ports per window, and the bits needed to number them
`define IO_PORT_COUNT 4
`define IO_PORT_INDEX_WIDTH 2

// Both bases are multiples of the port count, so the low address bits are the port index
`define IO_READ_BASE 1016
`define IO_WRITE_BASE 1020

`endif

`default_nettype wire

// ==== src/ioReadPredication.sv ====
// ---------------------------------------
// I/O read predication
// Checks operands A and B against the read port window and issues their
// one-hot read enables only when the whole instruction is ready
// ---------------------------------------

`include "ioPredication_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module ioReadPredication (
    input  logic clock,
    input  logic rst,
    input  logic enable,
    input  ioPredicationPkg::ioAddr addrA,
    input  ioPredicationPkg::ioAddr addrB,
    input  ioPredicationPkg::portMask emptyFull,
    input  logic ioReady,
    output logic notReadyA,
    output logic notReadyB,
    output ioPredicationPkg::portMask portEnableA,
    output ioPredicationPkg::portMask portEnableB
);

    ioPredicationPkg::portCheck resultA;
    ioPredicationPkg::portCheck resultB;

    // A read is blocked by an empty port, so the blocking state is 0
    ioPortCheck #(
        .baseAddr      (`IO_ADDR_WIDTH'(`IO_READ_BASE)),
        .blockingState (1'b0)
    ) checkA (
        .clock     (clock),
        .rst       (rst),
        .enable    (enable),
        .addr      (addrA),
        .emptyFull (emptyFull),
        .check     (resultA)
    );

    ioPortCheck #(
        .baseAddr      (`IO_ADDR_WIDTH'(`IO_READ_BASE)),
        .blockingState (1'b0)
    ) checkB (
        .clock     (clock),
        .rst       (rst),
        .enable    (enable),
        .addr      (addrB),
        .emptyFull (emptyFull),
        .check     (resultB)
    );

    // Both check results come out of stage 2 already aligned, so the
    // readiness bits go straight up to the top
    assign notReadyA = resultA.notReady;
    assign notReadyB = resultB.notReady;

    // ioReady comes back in the same cycle; a low level annuls both reads
    // so that no FIFO is popped for an instruction that will be re-issued
    assign portEnableA = (resultA.isIo && ioReady) ?
        ioPredicationPkg::oneHot(resultA.index) : '0;
    assign portEnableB = (resultB.isIo && ioReady) ?
        ioPredicationPkg::oneHot(resultB.index) : '0;

endmodule

`default_nettype wire

// ==== src/ioWritePredication.sv ====
// ---------------------------------------
// I/O write predication
// Checks destination D against the write port window and issues its one-hot
// write enable only when the whole instruction is ready
// ---------------------------------------

`include "ioPredication_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module ioWritePredication (
    input  logic clock,
    input  logic rst,
    input  logic enable,
    input  ioPredicationPkg::ioAddr addrD,
    input  ioPredicationPkg::portMask emptyFull,
    input  logic ioReady,
    output logic notReadyD,
    output ioPredicationPkg::portMask portEnable
);

    ioPredicationPkg::portCheck resultD;

    // ---------------------------------------
    // Destination check
    // ---------------------------------------

    // A write is blocked by a full port, so the blocking state is 1
    ioPortCheck #(
        .baseAddr      (`IO_ADDR_WIDTH'(`IO_WRITE_BASE)),
        .blockingState (1'b1)
    ) checkD (
        .clock     (clock),
        .rst       (rst),
        .enable    (enable),
        .addr      (addrD),
        .emptyFull (emptyFull),
        .check     (resultD)
    );

    // The destination's readiness joins the read operands' at the top
    assign notReadyD = resultD.notReady;

    // ---------------------------------------
    // Write enable
    // ---------------------------------------

    // Annulment happens here, after the check, because ioReady depends on all
    // three operands and only exists once every check has finished stage 2.
    // A blocked read therefore also suppresses a write to a port with room
    assign portEnable = (resultD.isIo && ioReady) ?
        ioPredicationPkg::oneHot(resultD.index) : '0;

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/ioPredicationPkg.sv
src/ioPortCheck.sv
src/ioReadPredication.sv
src/ioWritePredication.sv
src/ioPredication.sv
testbench/ioPredication_sva.sv
testbench/ioPredicationTb.sv

// ==== testbench/ioPredicationTb.sv ====
// ---------------------------------------
// I/O predication testbench
// Random instructions through the predication pipeline, checked every cycle
// against a reference model that follows the two-edge timing
// ---------------------------------------

`include "ioPredication_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module ioPredicationTb;

    localparam int clockPeriod = 40;
    localparam int resetCycles = 10;
    localparam int stimulusCycles = 2000;
    // Reset, stimulus, one drain cycle and a margin for the final compares
    localparam int timeoutCycles = resetCycles + stimulusCycles + 90;
    localparam int readBase = `IO_READ_BASE;
    localparam int writeBase = `IO_WRITE_BASE;
    localparam int portCount = `IO_PORT_COUNT;

    // One instruction as it enters stage 1
    typedef struct packed {
        logic enable;
        ioPredicationPkg::ioAddr addrA;
        ioPredicationPkg::ioAddr addrB;
        ioPredicationPkg::ioAddr addrD;
    } instruction;

    // The four outputs of one instruction once it has left stage 2
    typedef struct packed {
        logic ioReady;
        ioPredicationPkg::portMask readEnableA;
        ioPredicationPkg::portMask readEnableB;
        ioPredicationPkg::portMask writeEnable;
    } predictedOutputs;

    // An expected result, tagged with the rising edge where it is compared
    typedef struct packed {
        int unsigned dueCycle;
        predictedOutputs value;
    } expectation;

    logic clock;
    logic rst;
    logic enable;
    ioPredicationPkg::ioAddr addrA;
    ioPredicationPkg::ioAddr addrB;
    ioPredicationPkg::ioAddr addrD;
    ioPredicationPkg::portMask readEmptyFull;
    ioPredicationPkg::portMask writeEmptyFull;
    logic ioReady;
    ioPredicationPkg::portMask readPortEnableA;
    ioPredicationPkg::portMask readPortEnableB;
    ioPredicationPkg::portMask writePortEnable;

    // Two instructions are in flight, so at most a couple of entries wait here
    expectation expectQueue[$];
    int unsigned cycleCount = 0;
    int unsigned errorCount = 0;
    int unsigned checkCount = 0;

    ioPredication DUT (
        .clock           (clock),
        .rst             (rst),
        .enable          (enable),
        .addrA           (addrA),
        .addrB           (addrB),
        .addrD           (addrD),
        .readEmptyFull   (readEmptyFull),
        .writeEmptyFull  (writeEmptyFull),
        .ioReady         (ioReady),
        .readPortEnableA (readPortEnableA),
        .readPortEnableB (readPortEnableB),
        .writePortEnable (writePortEnable)
    );

    bind ioPredication ioPredicationSva sva (
        .clock           (clock),
        .rst             (rst),
        .ioReady         (ioReady),
        .readPortEnableA (readPortEnableA),
        .readPortEnableB (readPortEnableB),
        .writePortEnable (writePortEnable)
    );

    initial clock = 1'b0;
    always #(clockPeriod / 2) clock = ~clock;

    // ---------------------------------------
    // Reference model
    // ---------------------------------------

    // Expected outputs of one instruction, given the flags that are present
    // in the cycle after its addresses, when its checks reach stage 2
    function automatic predictedOutputs predictOutputs(
        input instruction instr,
        input ioPredicationPkg::portMask readFlags,
        input ioPredicationPkg::portMask writeFlags
    );
        predictedOutputs result;
        int offsetA;
        int offsetB;
        int offsetD;
        logic accessA;
        logic accessB;
        logic accessD;
        logic blockedA;
        logic blockedB;
        logic blockedD;
        logic ready;
        offsetA = int'(instr.addrA) - readBase;
        offsetB = int'(instr.addrB) - readBase;
        offsetD = int'(instr.addrD) - writeBase;
        // An operand is a port access only inside its window and when enabled
        accessA = instr.enable && offsetA >= 0 && offsetA < portCount;
        accessB = instr.enable && offsetB >= 0 && offsetB < portCount;
        accessD = instr.enable && offsetD >= 0 && offsetD < portCount;
        // An empty input port (flag 0) or a full output port (flag 1) blocks
        blockedA = accessA && !readFlags[ioPredicationPkg::portIndex'(offsetA)];
        blockedB = accessB && !readFlags[ioPredicationPkg::portIndex'(offsetB)];
        blockedD = accessD && writeFlags[ioPredicationPkg::portIndex'(offsetD)];
        ready = !(blockedA || blockedB || blockedD);
        result.ioReady = ready;
        // Enables only appear for a ready instruction, one bit per accessed port
        result.readEnableA = (accessA && ready) ?
            ioPredicationPkg::portMask'(1 << offsetA) : '0;
        result.readEnableB = (accessB && ready) ?
            ioPredicationPkg::portMask'(1 << offsetB) : '0;
        result.writeEnable = (accessD && ready) ?
            ioPredicationPkg::portMask'(1 << offsetD) : '0;
        return result;
    endfunction

    // Half of the addresses land in the operand's own window, the rest in
    // the other window or anywhere in the address space
    function automatic ioPredicationPkg::ioAddr randomAddress(
        input int ownBase,
        input int otherBase
    );
        int unsigned choice;
        int unsigned port;
        choice = $urandom_range(3, 0);
        port = $urandom_range(portCount - 1, 0);
        if (choice < 2) begin
            return ioPredicationPkg::ioAddr'(ownBase + port);
        end else if (choice == 2) begin
            return ioPredicationPkg::ioAddr'(otherBase + port);
        end
        return ioPredicationPkg::ioAddr'($urandom);
    endfunction

    task automatic checkValue(
        input string name,
        input ioPredicationPkg::portMask expected,
        input ioPredicationPkg::portMask actual
    );
        assert (actual === expected) else begin
            errorCount = errorCount + 1;
            $display("FAILED at %0d ns: %s expected %b, actual %b",
                $time, name, expected, actual);
        end
    endtask

    // ---------------------------------------
    // Stimulus
    // ---------------------------------------

    initial begin : stimulus
        instruction current;
        instruction previous;
        expectation entry;
        void'($urandom(32'h4582_abd8));
        rst = 1'b1;
        enable = 1'b0;
        addrA = '0;
        addrB = '0;
        addrD = '0;
        readEmptyFull = '0;
        writeEmptyFull = '0;
        // Reset clears the pipeline, which looks like an instruction with enable low
        previous = '0;
        repeat (resetCycles) @(posedge clock);
        for (int i = 0; i <= stimulusCycles; i++) begin
            @(negedge clock);
            rst = 1'b0;
            // The last pass is idle and only supplies flags to the final instruction
            current = '0;
            if (i < stimulusCycles) begin
                current.enable = ($urandom_range(7, 0) != 0);
                current.addrA = randomAddress(readBase, writeBase);
                current.addrB = randomAddress(readBase, writeBase);
                current.addrD = randomAddress(writeBase, readBase);
            end
            // Input ports are mostly non-empty and output ports mostly non-full
            readEmptyFull = ioPredicationPkg::portMask'($urandom | $urandom);
            writeEmptyFull = ioPredicationPkg::portMask'($urandom & $urandom);
            // These flags are sampled with the previous instruction in stage 2,
            // and its result is visible until the second rising edge from now
            entry.dueCycle = cycleCount + 2;
            entry.value = predictOutputs(previous, readEmptyFull, writeEmptyFull);
            expectQueue.push_back(entry);
            enable = current.enable;
            addrA = current.addrA;
            addrB = current.addrB;
            addrD = current.addrD;
            previous = current;
        end
        while (expectQueue.size() > 0) @(negedge clock);
        $display("Checked %0d cycles, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // ---------------------------------------
    // Comparison and timeout
    // ---------------------------------------

    // Outputs are read at the rising edge, before the registers update,
    // so they still hold the result of the cycle that just ended
    always @(posedge clock) begin : compare
        predictedOutputs expected;
        expectation head;
        cycleCount = cycleCount + 1;
        if (!rst) begin
            // Without a due entry the pipeline still shows its reset state
            expected = '0;
            expected.ioReady = 1'b1;
            if (expectQueue.size() > 0 && expectQueue[0].dueCycle == cycleCount) begin
                head = expectQueue.pop_front();
                expected = head.value;
            end
            checkValue("ioReady", ioPredicationPkg::portMask'(expected.ioReady),
                ioPredicationPkg::portMask'(ioReady));
            checkValue("readPortEnableA", expected.readEnableA, readPortEnableA);
            checkValue("readPortEnableB", expected.readEnableB, readPortEnableB);
            checkValue("writePortEnable", expected.writeEnable, writePortEnable);
            checkCount = checkCount + 1;
        end
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("Test failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/ioPredication_sva.sv ====
// ---------------------------------------
// I/O predication assertions
// Checks the port enables for one-hot form, annulment and reset state
// ---------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ioPredicationSva (
    input logic clock,
    input logic rst,
    input logic ioReady,
    input ioPredicationPkg::portMask readPortEnableA,
    input ioPredicationPkg::portMask readPortEnableB,
    input ioPredicationPkg::portMask writePortEnable
);

    // Each enable selects at most one port
    oneHotReadA: assert property (@(posedge clock) disable iff (rst)
        $onehot0(readPortEnableA))
        else $error("Read enable A selects more than one port");
    oneHotReadB: assert property (@(posedge clock) disable iff (rst)
        $onehot0(readPortEnableB))
        else $error("Read enable B selects more than one port");
    oneHotWrite: assert property (@(posedge clock) disable iff (rst)
        $onehot0(writePortEnable))
        else $error("Write enable selects more than one port");

    // An annulled instruction touches no port at all
    annulled: assert property (@(posedge clock) disable iff (rst)
        !ioReady |-> (readPortEnableA == '0 && readPortEnableB == '0
            && writePortEnable == '0))
        else $error("A port enable is set while ioReady is low");

    // Reset clears every stage, so the outputs come up idle
    resetState: assert property (@(posedge clock)
        rst |=> (ioReady && readPortEnableA == '0 && readPortEnableB == '0
            && writePortEnable == '0))
        else $error("Outputs are not idle in the cycle after reset");

endmodule

`default_nettype wire
